//--- hw/firPkg.sv
//********************************************************************
// Shared definitions for the streaming FIR filter.
// Holds the tap count, the sample and result widths, the constant
// coefficient table and the sample and result types. Design files take
// these with a wildcard import in their module header.
//********************************************************************

package firPkg;

	// Number of filter taps.
	localparam int tapCount = 20;

	// Width of both samples and coefficients.
	localparam int sampleWidth = 8;

	// Width of the index that walks the coefficient table.
	localparam int coefIndexWidth = $clog2(tapCount);

	// A full product needs twice the sample width, and the sum of tapCount
	// products needs log2 of tapCount more bits, so the result never overflows.
	localparam int accWidth = 2 * sampleWidth + $clog2(tapCount);

	// One signed sample or coefficient.
	typedef logic signed [sampleWidth-1:0] sample_t;

	// Registered filter output with its one-cycle strobe.
	typedef struct packed {
		logic strobe;
		logic signed [accWidth-1:0] value;
	} firResult_t;

	// Low-pass style coefficients. Entry n multiplies the sample that is n
	// strobes old. The table is deliberately not symmetric, so a reversed
	// tap order shows up in the impulse response.
	localparam sample_t coefTable [tapCount] = '{
		8'sd3, -8'sd5, 8'sd8, -8'sd12, 8'sd18,
		8'sd27, 8'sd41, 8'sd56, 8'sd69, 8'sd77,
		8'sd80, 8'sd74, 8'sd63, 8'sd49, 8'sd34,
		8'sd20, 8'sd9, -8'sd2, -8'sd6, -8'sd4
	};

endpackage

//--- hw/coefficientSource.sv
//********************************************************************
// Coefficient source for the FIR filter.
// While loadEnable is high it presents one table entry per cycle,
// starting at entry 0, and flags the cycle that carries the last one.
//********************************************************************

`timescale 1ns/1ps

module coefficientSource import firPkg::*; (
	input logic clock,
	input logic rstN,
	input logic loadEnable,
	output sample_t coefOut,
	output logic lastCoef
);

	// Index of the entry presented on coefOut in this cycle.
	logic [coefIndexWidth-1:0] index;

	// The entry is looked up straight from the index register, so the
	// coefficient is valid in the same cycle that the index points at it.
	assign coefOut = coefTable[index];

	// The final entry sits at tapCount-1.
	assign lastCoef = (index == coefIndexWidth'(tapCount - 1));

	// The index advances on every enabled cycle. It wraps to zero after the
	// last entry, and it is held at zero whenever loading is off, so the
	// next load always starts from entry 0.
	always_ff @(posedge clock) begin
		if (!rstN) begin
			index <= '0;
		end else if (!loadEnable || lastCoef) begin
			index <= '0;
		end else begin
			index <= index + 1'b1;
		end
	end

	// The index must stay inside the table.
	indexInRange: assert property (
		@(posedge clock) disable iff (!rstN)
		index <= coefIndexWidth'(tapCount - 1)
	);

endmodule

//--- hw/tapDelayLine.sv
//********************************************************************
// Delay line of tapCount signed samples.
// A shift request moves every tap one place toward the end and puts
// sampleIn into tap 0. Clear zeroes every tap and wins over shift.
//********************************************************************

`timescale 1ns/1ps

module tapDelayLine import firPkg::*; (
	input logic clock,
	input logic rstN,
	input logic shift,
	input logic clear,
	input sample_t sampleIn,
	output sample_t taps [tapCount]
);

	// Tap 0 holds the newest sample and tap tapCount-1 the oldest.
	// Both lines start from zero after reset, so the first results of a
	// run see an empty history.
	always_ff @(posedge clock) begin
		if (!rstN) begin
			for (int i = 0; i < tapCount; i++) begin
				taps[i] <= '0;
			end
		end else if (clear) begin
			for (int i = 0; i < tapCount; i++) begin
				taps[i] <= '0;
			end
		end else if (shift) begin
			// Oldest sample drops off the end.
			for (int i = tapCount - 1; i > 0; i--) begin
				taps[i] <= taps[i-1];
			end
			taps[0] <= sampleIn;
		end
	end

endmodule

//--- hw/productSum.sv
//********************************************************************
// Multiply and add stage of the FIR filter.
// Multiplies each data tap with its coefficient tap and adds all the
// products at full width. Purely combinational, with zero latency.
//********************************************************************

`timescale 1ns/1ps

module productSum import firPkg::*; (
	input sample_t dataTaps [tapCount],
	input sample_t coefTaps [tapCount],
	output logic signed [accWidth-1:0] sum
);

	// One full-width product per tap.
	logic signed [2*sampleWidth-1:0] products [tapCount];

	// The coefficient line was loaded with entry 0 first, so coefficient n
	// ends up in coefficient tap tapCount-1-n. Reading that tap against data
	// tap n gives the convolution order, where coefficient n meets the sample
	// that is n strobes old.
	always_comb begin
		for (int n = 0; n < tapCount; n++) begin
			products[n] = dataTaps[n] * coefTaps[tapCount-1-n];
		end
	end

	// Both sides are signed, so each product is sign-extended to accWidth
	// before it is added. The sum has enough headroom for tapCount
	// worst-case products.
	always_comb begin
		logic signed [accWidth-1:0] acc;
		acc = '0;
		for (int n = 0; n < tapCount; n++) begin
			acc = acc + products[n];
		end
		sum = acc;
	end

endmodule

//--- hw/firController.sv
//********************************************************************
// Sequencing FSM for the FIR filter.
// Loads the coefficients after reset or stop, then accepts sample
// strobes in run and registers the sum one cycle after each accepted
// strobe. A stop pulse clears the history and starts a reload.
//********************************************************************

`timescale 1ns/1ps

module firController import firPkg::*; (
	input logic clock,
	input logic rstN,
	input logic sampleStrobe,
	input logic stopPulse,
	input logic lastCoef,
	input logic signed [accWidth-1:0] sum,
	output logic loadEnable,
	output logic coefShift,
	output logic dataShift,
	output logic dataClear,
	output logic filterReady,
	output firResult_t result
);

	typedef enum logic [1:0] {
		stateIdle = 2'd0,
		stateLoad = 2'd1,
		stateRun = 2'd2
	} state_t;

	state_t state;

	// High in the cycle after a sample has entered the data line. The sum is
	// ready then, because productSum reads the updated taps directly.
	logic sumPending;

	// The source and the coefficient line both follow the load state, so
	// one coefficient moves in on every load cycle.
	assign loadEnable = (state == stateLoad);
	assign coefShift = (state == stateLoad);

	// Strobes count only in run. A stop in the same cycle wins, since the
	// history is about to be cleared anyway.
	assign dataShift = (state == stateRun) && sampleStrobe && !stopPulse;
	assign dataClear = (state == stateRun) && stopPulse;

	// The filter is ready exactly while the FSM is in run.
	assign filterReady = (state == stateRun);

	always_ff @(posedge clock) begin
		if (!rstN) begin
			state <= stateIdle;
		end else begin
			case (state)
				// Idle only lasts one cycle and always starts a load.
				stateIdle: state <= stateLoad;
				// The last coefficient shifts in on the same edge that
				// enters run.
				stateLoad: begin
					if (lastCoef) begin
						state <= stateRun;
					end
				end
				stateRun: begin
					if (stopPulse) begin
						state <= stateIdle;
					end
				end
				// Unused encoding, recover through idle.
				default: state <= stateIdle;
			endcase
		end
	end

	// Result register. The strobe is high for one cycle per accepted sample,
	// and the value holds until the next result.
	always_ff @(posedge clock) begin
		if (!rstN) begin
			sumPending <= 1'b0;
			result <= '0;
		end else begin
			sumPending <= dataShift;
			result.strobe <= sumPending;
			if (sumPending) begin
				result.value <= sum;
			end
		end
	end

	// Coefficients and samples never move in the same cycle.
	noLoadDuringShift: assert property (
		@(posedge clock) disable iff (!rstN)
		!(loadEnable && dataShift)
	);

	// Every result comes from a strobe that was given two edges earlier
	// while the filter was ready.
	resultFollowsStrobe: assert property (
		@(posedge clock) disable iff (!rstN)
		result.strobe |-> $past(sampleStrobe, 2) && $past(filterReady, 2)
	);

	// The source only reaches its last entry while it is being walked.
	lastCoefInLoad: assert property (
		@(posedge clock) disable iff (!rstN)
		lastCoef |-> (state == stateLoad)
	);

endmodule

//--- hw/firTop.sv
//********************************************************************
// Top level of the streaming FIR filter.
// Connects the coefficient source, the coefficient and data delay
// lines, the product sum and the controller. Strobe samples in only
// while filterReady is high; each gives one result strobe a cycle later.
//********************************************************************

`timescale 1ns/1ps

module firTop import firPkg::*; (
	input logic clock,
	input logic rstN,
	input logic sampleStrobe,
	input logic stopPulse,
	input sample_t sampleIn,
	output logic filterReady,
	output firResult_t result
);

	logic loadEnable;
	logic lastCoef;
	logic coefShift;
	logic dataShift;
	logic dataClear;
	sample_t coefOut;
	sample_t coefTaps [tapCount];
	sample_t dataTaps [tapCount];
	logic signed [accWidth-1:0] sum;

	coefficientSource coefSource (
		.clock(clock),
		.rstN(rstN),
		.loadEnable(loadEnable),
		.coefOut(coefOut),
		.lastCoef(lastCoef)
	);

	// A stop clears the coefficients too. They are reloaded before the
	// filter is ready again.
	tapDelayLine coefLine (
		.clock(clock),
		.rstN(rstN),
		.shift(coefShift),
		.clear(dataClear),
		.sampleIn(coefOut),
		.taps(coefTaps)
	);

	tapDelayLine dataLine (
		.clock(clock),
		.rstN(rstN),
		.shift(dataShift),
		.clear(dataClear),
		.sampleIn(sampleIn),
		.taps(dataTaps)
	);

	productSum macSum (
		.dataTaps(dataTaps),
		.coefTaps(coefTaps),
		.sum(sum)
	);

	firController controller (
		.clock(clock),
		.rstN(rstN),
		.sampleStrobe(sampleStrobe),
		.stopPulse(stopPulse),
		.lastCoef(lastCoef),
		.sum(sum),
		.loadEnable(loadEnable),
		.coefShift(coefShift),
		.dataShift(dataShift),
		.dataClear(dataClear),
		.filterReady(filterReady),
		.result(result)
	);

endmodule

//--- sim/firTb.sv
//********************************************************************
// Testbench for the streaming FIR filter.
// Runs reset and load, an impulse, random samples with gaps, strobes
// while not ready and a stop with reload. A sample history model and
// concurrent assertions check every result and the ready level.
//********************************************************************

`timescale 1ns/1ps

module firTb import firPkg::*; ();

	logic clock;
	logic rstN;
	logic sampleStrobe;
	logic stopPulse;
	sample_t sampleIn;
	logic filterReady;
	firResult_t result;

	// Model of the accepted samples. Entry 0 is the newest one.
	int history [tapCount];
	// Expected ready level and the edges left until it rises.
	logic modelReady;
	int readyCount;
	// Expected result pipeline, one stage per edge after a strobe.
	logic modelPending;
	logic expStrobe;
	logic signed [accWidth-1:0] expValue;

	int errorCount;
	int testsRun;
	int testsFailed;
	bit timedOut;

	initial begin
		clock = 1'b0;
		forever begin
			#50 clock = ~clock;
		end
	end

	firTop firTop_i (
		.clock(clock),
		.rstN(rstN),
		.sampleStrobe(sampleStrobe),
		.stopPulse(stopPulse),
		.sampleIn(sampleIn),
		.filterReady(filterReady),
		.result(result)
	);

	// Coefficient n weighs the sample that is n strobes old.
	function automatic int expectedSum();
		int acc;
		acc = 0;
		for (int n = 0; n < tapCount; n++) begin
			acc += int'(coefTable[n]) * history[n];
		end
		return acc;
	endfunction

	// The model follows the filter rules. Ready comes tapCount+1 edges after
	// reset release or a stop, only strobes seen while ready enter the
	// history, and each one gives a result one edge later.
	always @(posedge clock) begin
		if (!rstN) begin
			for (int i = 0; i < tapCount; i++) begin
				history[i] <= 0;
			end
			modelReady <= 1'b0;
			readyCount <= tapCount + 1;
			modelPending <= 1'b0;
			expStrobe <= 1'b0;
			expValue <= '0;
		end else begin
			expStrobe <= modelPending;
			if (modelPending) begin
				expValue <= accWidth'(expectedSum());
			end
			modelPending <= modelReady && sampleStrobe && !stopPulse;
			if (modelReady && stopPulse) begin
				// A stop empties the history and restarts the load count.
				for (int i = 0; i < tapCount; i++) begin
					history[i] <= 0;
				end
				modelReady <= 1'b0;
				readyCount <= tapCount + 1;
			end else if (modelReady && sampleStrobe) begin
				for (int i = tapCount - 1; i > 0; i--) begin
					history[i] <= history[i-1];
				end
				history[0] <= int'(sampleIn);
			end else if (!modelReady) begin
				if (readyCount == 1) begin
					modelReady <= 1'b1;
				end
				readyCount <= readyCount - 1;
			end
		end
	end

	task automatic reportFailure(input string msg);
		errorCount++;
		$display("FAIL %0t: %s", $time, msg);
	endtask

	readyLowInReset: assert property (@(posedge clock) !$past(rstN) |-> !filterReady)
		else reportFailure("filterReady is high during reset");

	readyMatches: assert property (@(posedge clock) disable iff (!rstN)
		filterReady == modelReady)
		else reportFailure($sformatf("filterReady is %0b, expected %0b",
			$sampled(filterReady), $sampled(modelReady)));

	stopDropsReady: assert property (@(posedge clock) disable iff (!rstN)
		filterReady && stopPulse |=> !filterReady)
		else reportFailure("filterReady stayed high after a stop");

	strobeMatches: assert property (@(posedge clock) disable iff (!rstN)
		result.strobe == expStrobe)
		else reportFailure($sformatf("result strobe is %0b, expected %0b",
			$sampled(result.strobe), $sampled(expStrobe)));

	valueMatches: assert property (@(posedge clock) disable iff (!rstN)
		expStrobe |-> result.value == expValue)
		else reportFailure($sformatf("result value is %0d, expected %0d",
			$sampled(result.value), $sampled(expValue)));

	// Inputs change 10 ns after the rising edge.
	task automatic nextCycle();
		@(posedge clock);
		#10;
	endtask

	task automatic strobeSample(input sample_t value);
		sampleStrobe = 1'b1;
		sampleIn = value;
		nextCycle();
		sampleStrobe = 1'b0;
	endtask

	task automatic pulseStop();
		stopPulse = 1'b1;
		nextCycle();
		stopPulse = 1'b0;
	endtask

	task automatic waitReady();
		int cycles;
		cycles = 0;
		while (!filterReady && cycles < 3 * tapCount) begin
			nextCycle();
			cycles++;
		end
		if (!filterReady) begin
			$display("Timeout: filterReady did not rise within %0d cycles", cycles);
			timedOut = 1'b1;
		end
	endtask

	// Waits until the last expected result has been checked.
	task automatic waitResultsDone();
		int cycles;
		cycles = 0;
		while ((modelPending || expStrobe) && cycles < 8) begin
			nextCycle();
			cycles++;
		end
		if (modelPending || expStrobe) begin
			$display("Timeout: results were still pending after %0d cycles", cycles);
			timedOut = 1'b1;
		end
	endtask

	task automatic finishTest(input string name, input int errorsBefore);
		int newErrors;
		newErrors = errorCount - errorsBefore;
		testsRun++;
		if (newErrors != 0 || timedOut) begin
			testsFailed++;
		end
		$display("Test %s finished with %0d errors%s", name, newErrors,
			timedOut ? " and a timeout" : "");
	endtask

	task automatic testResetAndLoad();
		int errorsBefore;
		errorsBefore = errorCount;
		repeat (4) nextCycle();
		rstN = 1'b1;
		waitReady();
		finishTest("reset and load", errorsBefore);
	endtask

	// The response to a unit impulse is the coefficient table itself.
	task automatic testImpulse();
		int errorsBefore;
		errorsBefore = errorCount;
		strobeSample(8'sd1);
		repeat (tapCount) strobeSample(8'sd0);
		waitResultsDone();
		finishTest("impulse", errorsBefore);
	endtask

	task automatic testRandomSamples();
		int errorsBefore;
		errorsBefore = errorCount;
		repeat (60) begin
			strobeSample(sample_t'($urandom()));
			repeat ($urandom_range(0, 3)) nextCycle();
		end
		waitResultsDone();
		finishTest("random samples", errorsBefore);
	endtask

	// Strobes during the reload must leave no trace in later results.
	task automatic testStrobesWhileNotReady();
		int errorsBefore;
		errorsBefore = errorCount;
		waitResultsDone();
		pulseStop();
		repeat (tapCount / 2) strobeSample(sample_t'($urandom()));
		waitReady();
		if (!timedOut) begin
			repeat (8) strobeSample(sample_t'($urandom()));
			waitResultsDone();
		end
		finishTest("strobes while not ready", errorsBefore);
	endtask

	task automatic testStopAndReload();
		int errorsBefore;
		errorsBefore = errorCount;
		repeat (tapCount) strobeSample(sample_t'($urandom()));
		waitResultsDone();
		pulseStop();
		waitReady();
		if (!timedOut) begin
			repeat (5) strobeSample(sample_t'($urandom()));
			waitResultsDone();
		end
		finishTest("stop and reload", errorsBefore);
	endtask

	task automatic endRun();
		$display("Tests run %0d, tests failed %0d, check errors %0d",
			testsRun, testsFailed, errorCount);
		if (errorCount == 0 && testsFailed == 0 && !timedOut) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	endtask

	initial begin
		rstN = 1'b0;
		sampleStrobe = 1'b0;
		stopPulse = 1'b0;
		sampleIn = '0;
		errorCount = 0;
		testsRun = 0;
		testsFailed = 0;
		timedOut = 1'b0;
		void'($urandom(32'h871153ad));
		testResetAndLoad();
		if (!timedOut) testImpulse();
		if (!timedOut) testRandomSamples();
		if (!timedOut) testStrobesWhileNotReady();
		if (!timedOut) testStopAndReload();
		endRun();
	end

endmodule

//--- vlog.f
hw/firPkg.sv
hw/coefficientSource.sv
hw/tapDelayLine.sv
hw/productSum.sv
hw/firController.sv
hw/firTop.sv
sim/firTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the FIR filter testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module firTb -f vlog.f -o firSim

./obj_dir/firSim > sim.log 2>&1 || true
cat sim.log

if grep -q "\*\* FAIL \*\*" sim.log; then
	echo "Simulation reported a failure, see sim.log"
	exit 1
fi

if ! grep -q "\*\* PASS \*\*" sim.log; then
	echo "Simulation ended without a result, see sim.log"
	exit 1
fi

echo "Simulation finished without failures"
